//--- logic/cpu_isa_pkg.sv
////////////////////////////////////////
// Instruction set definitions
// Opcode enum, instruction word, flags
// and the flag select bit positions
////////////////////////////////////////

package cpu_isa_pkg;

   ////////////////////////////////////////
   // Opcodes
   ////////////////////////////////////////

   // Top nibble of the instruction word
   typedef enum logic [3:0] {
      OP_NOP   = 4'h0,
      OP_LOAD  = 4'h1,   // AC <- mem[ea]
      OP_STORE = 4'h2,   // mem[ea] <- AC
      OP_ADD   = 4'h3,   // AC <- AC + mem[ea]
      OP_IN    = 4'h4,   // AC <- io[ea]
      OP_OUT   = 4'h5,   // io[ea] <- AC
      OP_JMP   = 4'h6,
      OP_FLAG  = 4'h7,   // Operand bits pick flag commands
      OP_SKL   = 4'h8,   // Skip if link set
      OP_INCA  = 4'h9
   } op_e;               // 0xA to 0xF run as NOP

   ////////////////////////////////////////
   // Words
   ////////////////////////////////////////

   typedef struct packed {
      op_e         op;
      logic        ind;      // Indirect addressing, resolved in datapath
      logic [10:0] operand;
   } instr_t;

   // Status flags held by the control unit
   typedef struct packed {
      logic link;
      logic ie;              // Interrupt enable
   } flags_t;

   // Operand bits for OP_FLAG
   localparam int FSEL_CLL = 10;
   localparam int FSEL_CPL = 9;
   localparam int FSEL_STI = 8;
   localparam int FSEL_CLI = 7;

endpackage

//--- logic/ucode_pkg.sv
////////////////////////////////////////
// Microcode definitions
// Bus unit and ALU enums, control word,
// ROM address, step limit, FSM states
////////////////////////////////////////

package ucode_pkg;

   ////////////////////////////////////////
   // Field encodings
   ////////////////////////////////////////

   // Unit driving the bus
   typedef enum logic [3:0] {
      R_NONE = 4'd0,
      R_PC   = 4'd1,
      R_AC   = 4'd2,
      R_AGL  = 4'd3,   // Address generation logic
      R_MBUS = 4'd4,   // Memory or I/O data in
      R_VEC  = 4'd5    // Interrupt vector
   } runit_e;

   // Unit loading from the bus
   typedef enum logic [2:0] {
      W_NONE = 3'd0,
      W_PC   = 3'd1,
      W_AC   = 3'd2,
      W_DR   = 3'd3,
      W_MAR  = 3'd4
   } wunit_e;

   typedef enum logic [3:0] {
      ALU_PASS = 4'd0,
      ALU_ADD  = 4'd1
   } alu_e;

   ////////////////////////////////////////
   // Control word and ROM address
   ////////////////////////////////////////

   // 24 bits, all strobes active high
   typedef struct packed {
      runit_e runit;
      wunit_e wunit;
      alu_e   opif;
      logic   cpl;     // Complement link
      logic   cll;     // Clear link
      logic   sti;
      logic   cli;
      logic   incac;
      logic   incpc;
      logic   incdr;
      logic   rsvd;    // Spare bit, always zero
      logic   mem;
      logic   io;
      logic   rd;
      logic   wen;
      logic   last;    // End of microprogram
   } ctl_word_t;

   typedef struct packed {
      logic              irq;    // Interrupt entry program
      logic              link;
      cpu_isa_pkg::op_e  op;
      logic [3:0]        upc;
   } uaddr_t;

   localparam int unsigned MAX_STEPS = 2;   // Longest microprogram

   typedef enum logic [1:0] {
      S_IDLE = 2'd0,
      S_RUN  = 2'd1,
      S_IRQ  = 2'd2
   } seq_state_e;

endpackage

//--- logic/upc_counter.sv
////////////////////////////////////////
// Micro-PC counter
// Steps on accepted control words
////////////////////////////////////////

`timescale 1ns/10ps

module upc_counter (
   input  logic       clk4,
   input  logic       arst_n,
   input  logic       advance,   // Word taken, more steps follow
   input  logic       clear,     // Word with last taken
   output logic [3:0] upc
);

   ////////////////////////////////////////
   // Counter
   ////////////////////////////////////////

   always_ff @(posedge clk4 or negedge arst_n) begin
      if (!arst_n) begin
         upc <= 4'd0;
      end else if (clear) begin
         upc <= 4'd0;              // Ready for next program
      end else if (advance) begin
         upc <= upc + 4'd1;
      end
   end

   ////////////////////////////////////////
   // Checks
   ////////////////////////////////////////

   // ROM must set last before the step limit
   a_upc_range : assert property (
      @(posedge clk4) disable iff (!arst_n)
      upc < ucode_pkg::MAX_STEPS
   ) else $error("upc ran past the longest microprogram");

endmodule

//--- logic/ucode_rom.sv
////////////////////////////////////////
// Microcode ROM
// Combinational table with one control
// word for each irq, link, opcode and upc
////////////////////////////////////////

`timescale 1ns/10ps

module ucode_rom (
   input  ucode_pkg::uaddr_t    uaddr,
   output ucode_pkg::ctl_word_t word
);

   always_comb begin
      // Unlisted addresses end the program at once
      word      = '0;
      word.last = 1'b1;

      if (uaddr.irq) begin
         ////////////////////////////////////////
         // Interrupt entry
         ////////////////////////////////////////
         if (uaddr.upc == 4'd0) begin
            word.runit = ucode_pkg::R_PC;     // Save return address
            word.wunit = ucode_pkg::W_DR;
            word.cli   = 1'b1;                // No nesting
            word.last  = 1'b0;
         end else if (uaddr.upc == 4'd1) begin
            word.runit = ucode_pkg::R_VEC;
            word.wunit = ucode_pkg::W_PC;
         end
      end else begin
         ////////////////////////////////////////
         // Instruction programs
         ////////////////////////////////////////
         case (uaddr.op)
            cpu_isa_pkg::OP_LOAD, cpu_isa_pkg::OP_ADD, cpu_isa_pkg::OP_IN: begin
               if (uaddr.upc == 4'd0) begin
                  word.runit = ucode_pkg::R_AGL;   // Effective address to MAR
                  word.wunit = ucode_pkg::W_MAR;
                  word.last  = 1'b0;
               end else if (uaddr.upc == 4'd1) begin
                  word.runit = ucode_pkg::R_MBUS;
                  word.wunit = ucode_pkg::W_AC;
                  word.rd    = 1'b1;
                  word.mem   = (uaddr.op != cpu_isa_pkg::OP_IN);
                  word.io    = (uaddr.op == cpu_isa_pkg::OP_IN);
                  if (uaddr.op == cpu_isa_pkg::OP_ADD) begin
                     word.opif = ucode_pkg::ALU_ADD;   // AC + bus
                  end
               end
            end
            cpu_isa_pkg::OP_STORE, cpu_isa_pkg::OP_OUT: begin
               if (uaddr.upc == 4'd0) begin
                  word.runit = ucode_pkg::R_AGL;
                  word.wunit = ucode_pkg::W_MAR;
                  word.last  = 1'b0;
               end else if (uaddr.upc == 4'd1) begin
                  word.runit = ucode_pkg::R_AC;    // AC onto data bus
                  word.wen   = 1'b1;
                  word.mem   = (uaddr.op == cpu_isa_pkg::OP_STORE);
                  word.io    = (uaddr.op == cpu_isa_pkg::OP_OUT);
               end
            end
            cpu_isa_pkg::OP_JMP: begin
               if (uaddr.upc == 4'd0) begin
                  word.runit = ucode_pkg::R_AGL;
                  word.wunit = ucode_pkg::W_PC;
               end
            end
            cpu_isa_pkg::OP_SKL: begin
               if (uaddr.upc == 4'd0) begin
                  word.incpc = uaddr.link;         // Skip taken on link
               end
            end
            cpu_isa_pkg::OP_INCA: begin
               if (uaddr.upc == 4'd0) begin
                  word.incac = 1'b1;
               end
            end
            // OP_FLAG gets its flag bits from the operand in the sequencer
            // NOP, spare codes and OP_FLAG keep the default word
            default: ;
         endcase
      end
   end

endmodule

//--- logic/flag_unit.sv
////////////////////////////////////////
// Flag unit
// Link and interrupt enable registers
////////////////////////////////////////

`timescale 1ns/10ps

module flag_unit (
   input  logic                 clk4,
   input  logic                 arst_n,
   input  ucode_pkg::ctl_word_t cmd,    // Word being transferred
   input  logic                 take,   // Transfer strobe
   output cpu_isa_pkg::flags_t  flags
);

   logic link_nxt;
   logic ie_nxt;

   ////////////////////////////////////////
   // Update rules
   ////////////////////////////////////////

   // Clear first, then complement
   assign link_nxt = (flags.link & ~cmd.cll) ^ cmd.cpl;

   // cli dominates sti
   assign ie_nxt = (flags.ie | cmd.sti) & ~cmd.cli;

   ////////////////////////////////////////
   // Registers
   ////////////////////////////////////////

   always_ff @(posedge clk4 or negedge arst_n) begin
      if (!arst_n) begin
         flags <= '0;
      end else if (take) begin
         flags.link <= link_nxt;
         flags.ie   <= ie_nxt;
      end
   end

   ////////////////////////////////////////
   // Checks
   ////////////////////////////////////////

   // Stale flag commands on an idle bus are ignored
   a_flags_need_take : assert property (
      @(posedge clk4) disable iff (!arst_n)
      !take |=> $stable(flags)
   ) else $error("flags changed without a control transfer");

endmodule

//--- logic/sequencer.sv
////////////////////////////////////////
// Microcode sequencer
// Instruction latch, idle/run/irq FSM,
// ROM address build, output handshake
////////////////////////////////////////

`timescale 1ns/10ps

module sequencer (
   input  logic                 clk4,
   input  logic                 arst_n,
   input  cpu_isa_pkg::instr_t  instr,
   input  logic                 instr_valid,
   input  logic                 irq,
   input  logic                 halt,
   input  cpu_isa_pkg::flags_t  flags,
   input  logic                 ctl_ready,
   output logic                 instr_ready,
   output ucode_pkg::ctl_word_t ctl,
   output logic                 ctl_valid,
   output logic                 ctl_xfer
);

   ucode_pkg::seq_state_e state, state_nxt;
   cpu_isa_pkg::instr_t   ir;          // Held instruction
   ucode_pkg::uaddr_t     uaddr;
   ucode_pkg::ctl_word_t  rom_word;
   logic [3:0]            upc;
   logic                  irq_pend;
   logic                  instr_xfer;
   logic                  prog_end;

   ////////////////////////////////////////
   // Handshakes
   ////////////////////////////////////////

   assign irq_pend    = irq & flags.ie;
   assign instr_ready = (state == ucode_pkg::S_IDLE) & ~halt & ~irq_pend;
   assign instr_xfer  = instr_valid & instr_ready;
   assign ctl_valid   = (state != ucode_pkg::S_IDLE) & ~halt;   // Halt stalls output
   assign ctl_xfer    = ctl_valid & ctl_ready;
   assign prog_end    = ctl_xfer & ctl.last;

   ////////////////////////////////////////
   // State machine
   ////////////////////////////////////////

   always_comb begin
      state_nxt = state;
      case (state)
         ucode_pkg::S_IDLE: begin
            if (!halt && irq_pend) begin
               state_nxt = ucode_pkg::S_IRQ;      // Interrupt wins over instr
            end else if (instr_xfer) begin
               state_nxt = ucode_pkg::S_RUN;
            end
         end
         ucode_pkg::S_RUN, ucode_pkg::S_IRQ: begin
            if (prog_end) state_nxt = ucode_pkg::S_IDLE;
         end
         default: state_nxt = ucode_pkg::S_IDLE;
      endcase
   end

   always_ff @(posedge clk4 or negedge arst_n) begin
      if (!arst_n) state <= ucode_pkg::S_IDLE;
      else         state <= state_nxt;
   end

   always_ff @(posedge clk4) begin
      if (instr_xfer) ir <= instr;
   end

   ////////////////////////////////////////
   // Micro-PC and ROM
   ////////////////////////////////////////

   upc_counter upc_counter_i (
      .clk4    (clk4),
      .arst_n  (arst_n),
      .advance (ctl_xfer & ~ctl.last),
      .clear   (prog_end),
      .upc     (upc)
   );

   assign uaddr.irq  = (state == ucode_pkg::S_IRQ);
   assign uaddr.link = flags.link;              // Live flag for SKL
   assign uaddr.op   = ir.op;
   assign uaddr.upc  = upc;

   ucode_rom ucode_rom_i (
      .uaddr (uaddr),
      .word  (rom_word)
   );

   // OP_FLAG takes its commands straight from the operand
   always_comb begin
      ctl = rom_word;
      if (!uaddr.irq && ir.op == cpu_isa_pkg::OP_FLAG) begin
         ctl.cll = ir.operand[cpu_isa_pkg::FSEL_CLL];
         ctl.cpl = ir.operand[cpu_isa_pkg::FSEL_CPL];
         ctl.sti = ir.operand[cpu_isa_pkg::FSEL_STI];
         ctl.cli = ir.operand[cpu_isa_pkg::FSEL_CLI];
      end
   end

   ////////////////////////////////////////
   // Checks
   ////////////////////////////////////////

   a_ctl_hold : assert property (
      @(posedge clk4) disable iff (!arst_n)
      ctl_valid && !ctl_ready |=> $stable(ctl)
   ) else $error("ctl changed under back-pressure");

   a_no_accept_busy : assert property (
      @(posedge clk4) disable iff (!arst_n)
      state != ucode_pkg::S_IDLE |-> !instr_ready
   ) else $error("instr_ready high while a program runs");

endmodule

//--- logic/micro_control.sv
////////////////////////////////////////
// Microcoded control unit, top level
// Sequencer plus flag unit
////////////////////////////////////////

`timescale 1ns/10ps

module micro_control (
   input  logic                 clk4,
   input  logic                 arst_n,
   input  cpu_isa_pkg::instr_t  instr,
   input  logic                 instr_valid,
   input  logic                 irq,
   input  logic                 halt,
   input  logic                 ctl_ready,
   output logic                 instr_ready,
   output ucode_pkg::ctl_word_t ctl,
   output logic                 ctl_valid,
   output cpu_isa_pkg::flags_t  flags
);

   logic ctl_xfer;   // Word accepted by datapath

   sequencer sequencer_i (
      .clk4        (clk4),
      .arst_n      (arst_n),
      .instr       (instr),
      .instr_valid (instr_valid),
      .irq         (irq),
      .halt        (halt),
      .flags       (flags),       // Feedback into ROM address
      .ctl_ready   (ctl_ready),
      .instr_ready (instr_ready),
      .ctl         (ctl),
      .ctl_valid   (ctl_valid),
      .ctl_xfer    (ctl_xfer)
   );

   flag_unit flag_unit_i (
      .clk4   (clk4),
      .arst_n (arst_n),
      .cmd    (ctl),
      .take   (ctl_xfer),
      .flags  (flags)
   );

endmodule

//--- verification/ucode_model.svh
////////////////////////////////////////
// Reference model of the microcode
// Expected words for instructions and
// interrupt entry, and flag updates
////////////////////////////////////////

`ifndef UCODE_MODEL_SVH
`define UCODE_MODEL_SVH

// Slot 0 is step 0; slot 1 only used when step 0 lacks last
typedef ucode_pkg::ctl_word_t [1:0] prog_t;

function automatic ucode_pkg::ctl_word_t bus_word(ucode_pkg::runit_e r,
                                                  ucode_pkg::wunit_e w,
                                                  logic last);
   ucode_pkg::ctl_word_t c;
   c       = '0;
   c.runit = r;
   c.wunit = w;
   c.last  = last;
   return c;
endfunction

// Expected program for one instruction from the flags at its start
function automatic prog_t instr_program(cpu_isa_pkg::instr_t i, cpu_isa_pkg::flags_t f);
   prog_t p;
   logic  is_io;
   p     = '0;
   p[0]  = bus_word(ucode_pkg::R_NONE, ucode_pkg::W_NONE, 1'b1);   // NOP shape
   is_io = (i.op == cpu_isa_pkg::OP_IN) || (i.op == cpu_isa_pkg::OP_OUT);
   case (i.op)
      cpu_isa_pkg::OP_LOAD, cpu_isa_pkg::OP_ADD, cpu_isa_pkg::OP_IN: begin
         p[0]     = bus_word(ucode_pkg::R_AGL, ucode_pkg::W_MAR, 1'b0);
         p[1]     = bus_word(ucode_pkg::R_MBUS, ucode_pkg::W_AC, 1'b1);
         p[1].rd  = 1'b1;
         p[1].mem = !is_io;
         p[1].io  = is_io;      // IN reads the I/O space
         if (i.op == cpu_isa_pkg::OP_ADD) p[1].opif = ucode_pkg::ALU_ADD;
      end
      cpu_isa_pkg::OP_STORE, cpu_isa_pkg::OP_OUT: begin
         p[0]     = bus_word(ucode_pkg::R_AGL, ucode_pkg::W_MAR, 1'b0);
         p[1]     = bus_word(ucode_pkg::R_AC, ucode_pkg::W_NONE, 1'b1);
         p[1].wen = 1'b1;
         p[1].mem = !is_io;
         p[1].io  = is_io;
      end
      cpu_isa_pkg::OP_JMP:  p[0] = bus_word(ucode_pkg::R_AGL, ucode_pkg::W_PC, 1'b1);
      cpu_isa_pkg::OP_FLAG: begin
         p[0].cll = i.operand[cpu_isa_pkg::FSEL_CLL];   // Select bits copied
         p[0].cpl = i.operand[cpu_isa_pkg::FSEL_CPL];
         p[0].sti = i.operand[cpu_isa_pkg::FSEL_STI];
         p[0].cli = i.operand[cpu_isa_pkg::FSEL_CLI];
      end
      cpu_isa_pkg::OP_SKL:  p[0].incpc = f.link;        // Skip only on link
      cpu_isa_pkg::OP_INCA: p[0].incac = 1'b1;
      default: ;                                        // Spare codes as NOP
   endcase
   return p;
endfunction

// Interrupt entry saves PC then jumps to the vector
function automatic prog_t irq_program();
   prog_t p;
   p        = '0;
   p[0]     = bus_word(ucode_pkg::R_PC, ucode_pkg::W_DR, 1'b0);
   p[0].cli = 1'b1;
   p[1]     = bus_word(ucode_pkg::R_VEC, ucode_pkg::W_PC, 1'b1);
   return p;
endfunction

// Flags after one transferred word
function automatic cpu_isa_pkg::flags_t next_flags(cpu_isa_pkg::flags_t f,
                                                   ucode_pkg::ctl_word_t w);
   cpu_isa_pkg::flags_t n;
   n = f;
   if (w.cll) n.link = 1'b0;      // Clear first
   if (w.cpl) n.link = ~n.link;   // Then complement
   if (w.sti) n.ie = 1'b1;
   if (w.cli) n.ie = 1'b0;        // cli wins
   return n;
endfunction

`endif

//--- verification/tb_micro_control.sv
////////////////////////////////////////
// Testbench for the control unit
// Random stimulus, model scoreboard,
// timeout and verdict
////////////////////////////////////////

`timescale 1ns/10ps

module tb_micro_control;

   `include "ucode_model.svh"

   localparam int N_INSTR    = 400;
   localparam int MAX_CYCLES = 20000;   // 400 instr x 2 steps, padded for stalls

   logic                 clk4;
   logic                 arst_n;
   cpu_isa_pkg::instr_t  instr;
   logic                 instr_valid;
   logic                 irq;
   logic                 halt;
   logic                 ctl_ready;
   logic                 instr_ready;
   logic                 ctl_valid;
   ucode_pkg::ctl_word_t ctl;
   cpu_isa_pkg::flags_t  flags;

   ucode_pkg::ctl_word_t exp_q[$];      // Words still to come, in order
   string                name_q[$];
   cpu_isa_pkg::flags_t  model_flags;
   logic                 busy;          // Model has a program in flight
   int                   seed;
   int                   cycles;
   int                   n_presented;
   int                   n_accepted;
   int                   n_irq;
   int                   n_words;

   micro_control micro_control_i (
      .clk4        (clk4),
      .arst_n      (arst_n),
      .instr       (instr),
      .instr_valid (instr_valid),
      .irq         (irq),
      .halt        (halt),
      .ctl_ready   (ctl_ready),
      .instr_ready (instr_ready),
      .ctl         (ctl),
      .ctl_valid   (ctl_valid),
      .flags       (flags)
   );

   always #10 clk4 = ~clk4;

   function automatic logic chance(int pct);
      int r;
      r = $random(seed);
      return ((r % 100 + 100) % 100) < pct;
   endfunction

   task automatic report_mismatch(string test, logic [31:0] exp_v, logic [31:0] act_v);
      $display("MISMATCH %s expected %h actual %h", test, exp_v, act_v);
      $display("TEST FAIL");
      $fatal(1, "check failed");
   endtask

   task automatic queue_program(prog_t p, string tag);
      exp_q.push_back(p[0]);
      name_q.push_back({tag, " step 0"});
      if (!p[0].last) begin
         exp_q.push_back(p[1]);
         name_q.push_back({tag, " step 1"});
      end
   endtask

   ////////////////////////////////////////
   // Stimulus driven 1 ns after the rising edge
   ////////////////////////////////////////

   always @(posedge clk4) begin
      logic [15:0] rbits;
      #1;
      if (cycles >= 10) arst_n = 1'b1;                 // 10 cycles of reset
      ctl_ready = chance(60);
      irq       = (n_accepted < N_INSTR) ? chance(10) : 1'b0;   // Quiet at the end
      halt      = chance(5);
      if (instr_valid && n_accepted == n_presented) instr_valid = 1'b0;
      if (arst_n && !instr_valid && n_presented < N_INSTR && chance(75)) begin
         rbits       = 16'($random(seed));
         instr       = cpu_isa_pkg::instr_t'(rbits);
         instr_valid = 1'b1;
         n_presented++;
      end
   end

   ////////////////////////////////////////
   // Scoreboard sampled mid cycle
   ////////////////////////////////////////

   always @(negedge clk4) begin
      ucode_pkg::ctl_word_t exp_w;
      string                tname;
      logic                 exp_ready;
      if (arst_n) begin
         exp_ready = !busy && !halt && !(irq && model_flags.ie);
         assert (flags == model_flags)
            else report_mismatch("flags", 32'(model_flags), 32'(flags));
         assert (instr_ready == exp_ready)
            else report_mismatch("instr_ready", 32'(exp_ready), 32'(instr_ready));
         assert (ctl_valid == (busy && !halt))
            else report_mismatch("ctl_valid", 32'(busy && !halt), 32'(ctl_valid));
         if (ctl_valid && ctl_ready) begin
            exp_w = exp_q.pop_front();
            tname = name_q.pop_front();
            assert (ctl == exp_w) else report_mismatch(tname, 32'(exp_w), 32'(ctl));
            model_flags = next_flags(model_flags, exp_w);   // Lands on next edge
            n_words++;
            if (exp_w.last) busy = 1'b0;
         end else if (!busy) begin
            if (!halt && irq && model_flags.ie) begin      // Interrupt first
               queue_program(irq_program(), "irq entry");
               busy = 1'b1;
               n_irq++;
            end else if (instr_valid && exp_ready) begin
               queue_program(instr_program(instr, model_flags),
                             $sformatf("op %0h operand %h", instr.op, instr.operand));
               busy = 1'b1;
               n_accepted++;
            end
         end
      end
   end

   // Hang guard
   always @(posedge clk4) begin
      cycles++;
      if (cycles >= MAX_CYCLES) begin
         $display("Timeout after %0d cycles, %0d instructions accepted", cycles, n_accepted);
         $display("TEST FAIL");
         $fatal(1, "timeout");
      end
   end

   initial begin
      seed        = 52;
      clk4        = 1'b0;
      arst_n      = 1'b0;
      instr       = '0;
      instr_valid = 1'b0;
      irq         = 1'b0;
      halt        = 1'b0;
      ctl_ready   = 1'b0;
      model_flags = '0;
      busy        = 1'b0;
      cycles      = 0;
      n_presented = 0;
      n_accepted  = 0;
      n_irq       = 0;
      n_words     = 0;
      while (!(n_accepted == N_INSTR && !busy)) @(posedge clk4);
      repeat (2) @(posedge clk4);                     // Last flag compare
      if (n_irq > 0) begin
         $display("%0d words checked, %0d interrupts", n_words, n_irq);
         $display("TEST PASS");
         $finish;
      end else begin
         $display("No interrupt entry was taken during the run");
         $display("TEST FAIL");
         $fatal(1, "interrupt entry not exercised");
      end
   end

endmodule

//--- micro_control.f
+incdir+verification
logic/cpu_isa_pkg.sv
logic/ucode_pkg.sv
logic/upc_counter.sv
logic/ucode_rom.sv
logic/flag_unit.sv
logic/sequencer.sv
logic/micro_control.sv
verification/tb_micro_control.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the micro_control testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_micro_control \
   -f micro_control.f \
   -o sim_micro_control
./obj_dir/sim_micro_control
